//--- source/core_mem_pkg.sv
//==============================
// Shared widths, vector numbering and
// queue depths for the memory slice
//==============================
`default_nettype none

package core_mem_pkg;

	// Bus widths
	localparam int data_w = 32;
	localparam int order_w = 2;
	localparam int lane_w = $clog2(data_w / 8);

	// Access-size codes
	localparam logic [order_w-1:0] order_byte = 2'd0;
	localparam logic [order_w-1:0] order_half = 2'd1;
	localparam logic [order_w-1:0] order_word = 2'd2;

	// Software vectors sit below the external interrupt range
	localparam int irq_num_w = 6;
	localparam int vector_w = 7;
	localparam int ext_vector_base = 64;
	localparam int ict_entries = 64;
	localparam int idt_entry_bytes = 4;

	// Queue depths
	localparam int exe_queue_depth = 4;
	localparam int exe_ptr_w = $clog2(exe_queue_depth);
	localparam int max_outstanding = 4;
	localparam int out_ptr_w = $clog2(max_outstanding);

	// Vector unit FSM encoding
	localparam logic [1:0] vec_st_idle = 2'd0;
	localparam logic [1:0] vec_st_req = 2'd1;
	localparam logic [1:0] vec_st_wait = 2'd2;

endpackage

`default_nettype wire

//--- source/ldst_req_if.sv
//==============================
// Load/store request and read
// response link to the arbiter
//==============================
`timescale 1ns/100ps
`default_nettype none

interface ldst_req_if
	import core_mem_pkg::*;
();

	// Request taken when req is high and busy is low
	logic req;
	logic busy;
	logic [order_w-1:0] order;
	// 1 = read, 0 = write
	logic rw;
	logic [data_w-1:0] addr;
	logic [data_w-1:0] wdata;

	// One pulse per read, in issue order
	logic valid;
	logic [data_w-1:0] rdata;

	modport requester (output req, order, rw, addr, wdata, input busy, valid, rdata);
	modport arbiter (input req, order, rw, addr, wdata, output busy, valid, rdata);

endinterface

`default_nettype wire

//--- source/exe_ldst_queue.sv
//==============================
// Execution-side load/store FIFO
// with load data alignment
//==============================
`timescale 1ns/100ps
`default_nettype none

module exe_ldst_queue
	import core_mem_pkg::*;
(
	input wire clock,
	input wire arst_n,
	input wire exe_req,
	output logic exe_busy,
	input wire [order_w-1:0] exe_order,
	input wire exe_rw,
	input wire [data_w-1:0] exe_addr,
	input wire [data_w-1:0] exe_wdata,
	output logic exe_valid,
	output logic [data_w-1:0] exe_rdata,
	ldst_req_if.requester mem
);

	// Request FIFO
	logic [order_w-1:0] q_order [exe_queue_depth];
	logic q_rw [exe_queue_depth];
	logic [data_w-1:0] q_addr [exe_queue_depth];
	logic [data_w-1:0] q_wdata [exe_queue_depth];
	logic [exe_ptr_w-1:0] wr_ptr;
	logic [exe_ptr_w-1:0] rd_ptr;
	logic [exe_ptr_w:0] count;
	logic push;
	logic pop;
	logic [data_w-1:0] lane_wdata;

	// Size and byte offset of each read in flight
	logic [order_w-1:0] pend_order [max_outstanding];
	logic [lane_w-1:0] pend_off [max_outstanding];
	logic [out_ptr_w-1:0] pend_wr;
	logic [out_ptr_w-1:0] pend_rd;
	logic [data_w-1:0] shifted;

	assign exe_busy = (count == (exe_ptr_w + 1)'(exe_queue_depth));
	assign push = exe_req && !exe_busy;
	assign pop = mem.req && !mem.busy;

	// Store data copied into every lane of its size
	always_comb begin
		case (exe_order)
			order_byte: lane_wdata = {4{exe_wdata[7:0]}};
			order_half: lane_wdata = {2{exe_wdata[15:0]}};
			default: lane_wdata = exe_wdata;
		endcase
	end

	always_ff @(posedge clock) begin
		if (push) begin
			q_order[wr_ptr] <= exe_order;
			q_rw[wr_ptr] <= exe_rw;
			q_addr[wr_ptr] <= exe_addr;
			q_wdata[wr_ptr] <= lane_wdata;
		end
		if (pop && q_rw[rd_ptr]) begin
			pend_order[pend_wr] <= q_order[rd_ptr];
			pend_off[pend_wr] <= q_addr[rd_ptr][lane_w-1:0];
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			pend_wr <= '0;
			pend_rd <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			if (pop && q_rw[rd_ptr])
				pend_wr <= pend_wr + 1'b1;
			if (mem.valid)
				pend_rd <= pend_rd + 1'b1;
		end
	end

	// Head of the FIFO drives the link
	assign mem.req = (count != '0);
	assign mem.order = q_order[rd_ptr];
	assign mem.rw = q_rw[rd_ptr];
	assign mem.addr = q_addr[rd_ptr];
	assign mem.wdata = q_wdata[rd_ptr];

	// Addressed lane moves down to bit 0, then zero-extended
	assign shifted = mem.rdata >> {pend_off[pend_rd], 3'b000};

	always_comb begin
		case (pend_order[pend_rd])
			order_byte: exe_rdata = data_w'(shifted[7:0]);
			order_half: exe_rdata = data_w'(shifted[15:0]);
			default: exe_rdata = shifted;
		endcase
	end

	assign exe_valid = mem.valid;

endmodule

`default_nettype wire

//--- source/irq_vector_unit.sv
//==============================
// Interrupt vector unit with ICT, selection
// and descriptor-table handler fetch
//==============================
`timescale 1ns/100ps
`default_nettype none

module irq_vector_unit
	import core_mem_pkg::*;
(
	input wire clock,
	input wire arst_n,
	// External interrupt
	input wire irq_valid,
	input wire [irq_num_w-1:0] irq_num,
	output logic irq_ack,
	// Software interrupt
	input wire swi_req,
	input wire [irq_num_w-1:0] swi_num,
	output logic swi_ack,
	// Configuration table write
	input wire ict_write,
	input wire [irq_num_w-1:0] ict_entry,
	input wire ict_mask,
	input wire ict_valid,
	input wire [data_w-1:0] idt_base,
	// New program counter
	output logic pc_set,
	output logic [data_w-1:0] pc,
	ldst_req_if.requester mem
);

	logic [ict_entries-1:0] ict_mask_q;
	logic [ict_entries-1:0] ict_valid_q;
	logic [1:0] state;
	logic take;
	logic [vector_w-1:0] sel_vector;
	logic [data_w-1:0] fetch_addr;
	logic fetch_done;

	// One mask and one valid bit per table entry
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ict_mask_q <= '0;
			ict_valid_q <= '0;
		end else if (ict_write) begin
			ict_mask_q[ict_entry] <= ict_mask;
			ict_valid_q[ict_entry] <= ict_valid;
		end
	end

	// Software first when idle
	always_comb begin
		swi_ack = 1'b0;
		irq_ack = 1'b0;
		take = 1'b0;
		sel_vector = '0;
		if (state == vec_st_idle) begin
			if (swi_req) begin
				swi_ack = 1'b1;
				take = 1'b1;
				sel_vector = vector_w'(swi_num);
			end else if (irq_valid) begin
				irq_ack = 1'b1;
				// Masked or invalid entries are dropped after the ack
				if (ict_valid_q[irq_num] && !ict_mask_q[irq_num]) begin
					take = 1'b1;
					sel_vector = vector_w'(ext_vector_base) + vector_w'(irq_num);
				end
			end
		end
	end

	// Descriptor address for the selected vector
	always_ff @(posedge clock) begin
		if (take)
			fetch_addr <= idt_base + data_w'(sel_vector) * data_w'(idt_entry_bytes);
	end

	assign fetch_done = (state == vec_st_wait) && mem.valid;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= vec_st_idle;
			pc_set <= 1'b0;
		end else begin
			pc_set <= fetch_done;
			case (state)
				vec_st_idle: begin
					if (take)
						state <= vec_st_req;
				end
				vec_st_req: begin
					if (!mem.busy)
						state <= vec_st_wait;
				end
				vec_st_wait: begin
					if (mem.valid)
						state <= vec_st_idle;
				end
				default: state <= vec_st_idle;
			endcase
		end
	end

	// Handler address
	always_ff @(posedge clock) begin
		if (fetch_done)
			pc <= mem.rdata;
	end

	// Word read of the descriptor entry
	assign mem.req = (state == vec_st_req);
	assign mem.rw = 1'b1;
	assign mem.order = order_word;
	assign mem.addr = fetch_addr;
	assign mem.wdata = '0;

endmodule

`default_nettype wire

//--- source/ldst_pipe_arbiter.sv
//==============================
// Joins both requesters onto the data
// port and routes reads by owner
//==============================
`timescale 1ns/100ps
`default_nettype none

module ldst_pipe_arbiter
	import core_mem_pkg::*;
(
	input wire clock,
	input wire arst_n,
	ldst_req_if.arbiter exe_side,
	ldst_req_if.arbiter vec_side,
	// Data-memory port
	output logic data_req,
	input wire data_lock,
	output logic [order_w-1:0] data_order,
	output logic data_rw,
	output logic [data_w-1:0] data_addr,
	output logic [data_w-1:0] data_wdata,
	input wire data_valid,
	input wire [data_w-1:0] data_rdata
);

	// Owner bit set marks a vector-side read in flight
	logic owner_q [max_outstanding];
	logic [out_ptr_w-1:0] own_wr;
	logic [out_ptr_w-1:0] own_rd;
	logic [out_ptr_w:0] inflight;
	logic rd_full;
	logic sel_vec;
	logic accept;
	logic rd_push;

	assign rd_full = (inflight == (out_ptr_w + 1)'(max_outstanding));

	// Vector side wins whenever it requests
	assign sel_vec = vec_side.req;

	assign data_req = (vec_side.req || exe_side.req) && !rd_full;
	assign data_order = sel_vec ? vec_side.order : exe_side.order;
	assign data_rw = sel_vec ? vec_side.rw : exe_side.rw;
	assign data_addr = sel_vec ? vec_side.addr : exe_side.addr;
	assign data_wdata = sel_vec ? vec_side.wdata : exe_side.wdata;

	assign accept = data_req && !data_lock;
	assign rd_push = accept && data_rw;

	assign vec_side.busy = data_lock || rd_full;
	assign exe_side.busy = data_lock || rd_full || vec_side.req;

	always_ff @(posedge clock) begin
		if (rd_push)
			owner_q[own_wr] <= sel_vec;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			own_wr <= '0;
			own_rd <= '0;
			inflight <= '0;
		end else begin
			if (rd_push)
				own_wr <= own_wr + 1'b1;
			if (data_valid)
				own_rd <= own_rd + 1'b1;
			if (rd_push && !data_valid)
				inflight <= inflight + 1'b1;
			else if (data_valid && !rd_push)
				inflight <= inflight - 1'b1;
		end
	end

	// Responses return in order, so the oldest owner takes this one
	assign vec_side.valid = data_valid && owner_q[own_rd];
	assign exe_side.valid = data_valid && !owner_q[own_rd];
	assign vec_side.rdata = data_rdata;
	assign exe_side.rdata = data_rdata;

endmodule

`default_nettype wire

//--- source/core_mem_top.sv
//==============================
// Load/store and interrupt-vector
// slice on one data-memory port
//==============================
`timescale 1ns/100ps
`default_nettype none

module core_mem_top
	import core_mem_pkg::*;
(
	input wire clock,
	input wire arst_n,
	// Execution load/store
	input wire exe_req,
	output logic exe_busy,
	input wire [order_w-1:0] exe_order,
	input wire exe_rw,
	input wire [data_w-1:0] exe_addr,
	input wire [data_w-1:0] exe_wdata,
	output logic exe_valid,
	output logic [data_w-1:0] exe_rdata,
	// Interrupts
	input wire irq_valid,
	input wire [irq_num_w-1:0] irq_num,
	output logic irq_ack,
	input wire swi_req,
	input wire [irq_num_w-1:0] swi_num,
	output logic swi_ack,
	// Configuration table
	input wire ict_write,
	input wire [irq_num_w-1:0] ict_entry,
	input wire ict_mask,
	input wire ict_valid,
	input wire [data_w-1:0] idt_base,
	output logic pc_set,
	output logic [data_w-1:0] pc,
	// Data memory
	output logic data_req,
	input wire data_lock,
	output logic [order_w-1:0] data_order,
	output logic data_rw,
	output logic [data_w-1:0] data_addr,
	output logic [data_w-1:0] data_wdata,
	input wire data_valid,
	input wire [data_w-1:0] data_rdata
);

	ldst_req_if exe_ldst ();
	ldst_req_if vec_ldst ();

	exe_ldst_queue u_exe_ldst_queue (
		.clock(clock),
		.arst_n(arst_n),
		.exe_req(exe_req),
		.exe_busy(exe_busy),
		.exe_order(exe_order),
		.exe_rw(exe_rw),
		.exe_addr(exe_addr),
		.exe_wdata(exe_wdata),
		.exe_valid(exe_valid),
		.exe_rdata(exe_rdata),
		.mem(exe_ldst.requester)
	);

	irq_vector_unit u_irq_vector_unit (
		.clock(clock),
		.arst_n(arst_n),
		.irq_valid(irq_valid),
		.irq_num(irq_num),
		.irq_ack(irq_ack),
		.swi_req(swi_req),
		.swi_num(swi_num),
		.swi_ack(swi_ack),
		.ict_write(ict_write),
		.ict_entry(ict_entry),
		.ict_mask(ict_mask),
		.ict_valid(ict_valid),
		.idt_base(idt_base),
		.pc_set(pc_set),
		.pc(pc),
		.mem(vec_ldst.requester)
	);

	ldst_pipe_arbiter u_ldst_pipe_arbiter (
		.clock(clock),
		.arst_n(arst_n),
		.exe_side(exe_ldst.arbiter),
		.vec_side(vec_ldst.arbiter),
		.data_req(data_req),
		.data_lock(data_lock),
		.data_order(data_order),
		.data_rw(data_rw),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_valid(data_valid),
		.data_rdata(data_rdata)
	);

endmodule

`default_nettype wire

//--- tb/core_mem_assert.sv
//==============================
// Arbiter protocol checks, bound
// into ldst_pipe_arbiter
//==============================
`timescale 1ns/100ps
`default_nettype none

module core_mem_assert
	import core_mem_pkg::*;
(
	input wire clock,
	input wire arst_n,
	input wire data_req,
	input wire data_valid,
	input wire [out_ptr_w:0] inflight,
	input wire vec_req,
	input wire vec_busy,
	input wire exe_valid,
	input wire vec_valid
);

	int assert_fails = 0;
	logic vec_grant;
	logic [out_ptr_w:0] vec_inflight;

	// Every vector-side request is a read
	assign vec_grant = vec_req && !vec_busy;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			vec_inflight <= '0;
		else if (vec_grant && !vec_valid)
			vec_inflight <= vec_inflight + 1'b1;
		else if (vec_valid && !vec_grant)
			vec_inflight <= vec_inflight - 1'b1;
	end

	// A response needs a read in flight
	resp_has_read: assert property (@(posedge clock) disable iff (!arst_n)
		data_valid |-> inflight != '0)
	else begin
		assert_fails++;
		$error("data_valid arrived with no read in flight");
	end

	// Each response goes to a side with its own read in flight
	resp_to_owner: assert property (@(posedge clock) disable iff (!arst_n)
		!(vec_valid && vec_inflight == '0) && !(exe_valid && inflight == vec_inflight))
	else begin
		assert_fails++;
		$error("read response went to a side with no read in flight");
	end

	// Port stays quiet in reset
	no_req_in_reset: assert property (@(posedge clock) !arst_n |-> !data_req)
	else begin
		assert_fails++;
		$error("data_req high while reset is asserted");
	end

endmodule

bind ldst_pipe_arbiter core_mem_assert u_core_mem_assert (
	.clock(clock),
	.arst_n(arst_n),
	.data_req(data_req),
	.data_valid(data_valid),
	.inflight(inflight),
	.vec_req(vec_side.req),
	.vec_busy(vec_side.busy),
	.exe_valid(exe_side.valid),
	.vec_valid(vec_side.valid)
);

`default_nettype wire

//--- tb/core_mem_tb.sv
//==============================
// Trace-driven testbench with a
// data-memory model for core_mem_top
//==============================
`timescale 1ns/100ps
`default_nettype none

module core_mem_tb
	import core_mem_pkg::*;
();

	localparam int clk_period = 40;
	localparam int trace_max = 64;
	localparam int item_cycles = 100;
	localparam logic [31:0] idt_base_addr = 32'h0000_2000;

	logic clock;
	logic arst_n;
	logic exe_req;
	logic exe_busy;
	logic [order_w-1:0] exe_order;
	logic exe_rw;
	logic [data_w-1:0] exe_addr;
	logic [data_w-1:0] exe_wdata;
	logic exe_valid;
	logic [data_w-1:0] exe_rdata;
	logic irq_valid;
	logic [irq_num_w-1:0] irq_num;
	logic irq_ack;
	logic swi_req;
	logic [irq_num_w-1:0] swi_num;
	logic swi_ack;
	logic ict_write;
	logic [irq_num_w-1:0] ict_entry;
	logic ict_mask;
	logic ict_valid;
	logic [data_w-1:0] idt_base;
	logic pc_set;
	logic [data_w-1:0] pc;
	logic data_req;
	logic data_lock;
	logic [order_w-1:0] data_order;
	logic data_rw;
	logic [data_w-1:0] data_addr;
	logic [data_w-1:0] data_wdata;
	logic data_valid;
	logic [data_w-1:0] data_rdata;

	// Trace records, memory contents and expected results
	logic [data_w-1:0] trace [trace_max*5];
	logic [data_w-1:0] mem_words [bit [29:0]];
	logic [data_w-1:0] rsp_q [$];
	logic [data_w-1:0] exp_load [$];
	logic [data_w-1:0] exp_pc [$];
	int item_count;
	bit trace_ready;

	core_mem_top u_core_mem_top (.*);

	initial clock = 1'b0;
	always #(clk_period / 2) clock = ~clock;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_load_data(input logic [data_w-1:0] expected,
			input logic [data_w-1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("[FAIL] exe_rdata expected %h got %h", expected, actual));
	endtask

	task automatic check_vector_pc(input logic [data_w-1:0] expected,
			input logic [data_w-1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("[FAIL] pc expected %h got %h", expected, actual));
	endtask

	// Unwritten words read back a pattern of their own address
	function automatic logic [data_w-1:0] read_word(input logic [data_w-1:0] addr);
		if (mem_words.exists(addr[31:2]))
			return mem_words[addr[31:2]];
		return {addr[31:2], 2'b00} ^ 32'h5a5a_a5a5;
	endfunction

	task automatic store_lanes(input logic [data_w-1:0] addr,
			input logic [order_w-1:0] order, input logic [data_w-1:0] wdata);
		logic [data_w-1:0] word;
		word = read_word(addr);
		case (order)
			order_byte: word[8*addr[1:0] +: 8] = wdata[8*addr[1:0] +: 8];
			order_half: word[16*addr[1] +: 16] = wdata[16*addr[1] +: 16];
			default: word = wdata;
		endcase
		mem_words[addr[31:2]] = word;
	endtask

	// Each stimulus task starts and ends on a falling edge
	task automatic issue_exe(input logic rw, input logic [order_w-1:0] order,
			input logic [data_w-1:0] addr, input logic [data_w-1:0] wdata);
		exe_req = 1'b1;
		exe_rw = rw;
		exe_order = order;
		exe_addr = addr;
		exe_wdata = wdata;
		while (exe_busy)
			@(negedge clock);
		@(negedge clock);
		exe_req = 1'b0;
	endtask

	task automatic raise_swi(input logic [irq_num_w-1:0] num);
		swi_req = 1'b1;
		swi_num = num;
		#1;
		while (!swi_ack) begin
			@(negedge clock);
			#1;
		end
		@(negedge clock);
		swi_req = 1'b0;
	endtask

	task automatic raise_irq(input logic [irq_num_w-1:0] num);
		irq_valid = 1'b1;
		irq_num = num;
		#1;
		while (!irq_ack) begin
			@(negedge clock);
			#1;
		end
		@(negedge clock);
		irq_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_load.size() != 0 || exp_pc.size() != 0)
			@(negedge clock);
	endtask

	// Memory model with random lock and in-order delayed reads
	initial begin
		void'($urandom(87));
		data_lock = 1'b0;
		data_valid = 1'b0;
		data_rdata = '0;
		forever begin
			@(negedge clock);
			data_lock = ($urandom % 4 == 0);
			data_valid = 1'b0;
			if (rsp_q.size() > 0 && $urandom % 3 != 0) begin
				data_valid = 1'b1;
				data_rdata = rsp_q.pop_front();
			end
			#10;
			if (arst_n && data_req && !data_lock) begin
				if (data_rw)
					rsp_q.push_back(read_word(data_addr));
				else
					store_lanes(data_addr, data_order, data_wdata);
			end
		end
	end

	// Results sampled mid-cycle well clear of both edges
	always @(negedge clock) begin
		#15;
		if (exe_valid) begin
			if (exp_load.size() == 0)
				abort_run("Load data came back with no load outstanding");
			else
				check_load_data(exp_load.pop_front(), exe_rdata);
		end
		if (pc_set) begin
			if (exp_pc.size() == 0)
				abort_run("pc_set pulsed with no vector fetch expected");
			else
				check_vector_pc(exp_pc.pop_front(), pc);
		end
	end

	initial begin
		wait (trace_ready);
		#((item_count + 4) * item_cycles * clk_period);
		abort_run("Watchdog expired before the trace finished");
	end

	initial begin
		int idx;
		logic [data_w-1:0] op;
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		logic [data_w-1:0] c;
		logic [data_w-1:0] d;
		arst_n = 1'b0;
		exe_req = 1'b0;
		exe_order = order_word;
		exe_rw = 1'b0;
		exe_addr = '0;
		exe_wdata = '0;
		irq_valid = 1'b0;
		irq_num = '0;
		swi_req = 1'b0;
		swi_num = '0;
		ict_write = 1'b0;
		ict_entry = '0;
		ict_mask = 1'b0;
		ict_valid = 1'b0;
		idt_base = idt_base_addr;
		for (idx = 0; idx < trace_max * 5; idx++)
			trace[idx] = '0;
		$readmemh("tb/core_mem_trace.txt", trace);
		item_count = 0;
		while (item_count < trace_max && trace[item_count*5] != '0)
			item_count++;
		trace_ready = 1'b1;
		repeat (2) @(negedge clock);
		arst_n = 1'b1;
		for (idx = 0; idx < item_count; idx++) begin
			op = trace[idx*5];
			a = trace[idx*5+1];
			b = trace[idx*5+2];
			c = trace[idx*5+3];
			d = trace[idx*5+4];
			case (op)
				1: mem_words[a[31:2]] = b;
				2: begin
					ict_write = 1'b1;
					ict_entry = a[irq_num_w-1:0];
					ict_mask = b[0];
					ict_valid = c[0];
					@(negedge clock);
					ict_write = 1'b0;
				end
				3: issue_exe(1'b0, c[order_w-1:0], a, b);
				4, 8: begin
					exp_load.push_back(b);
					issue_exe(1'b1, c[order_w-1:0], a, '0);
					if (op == 4)
						wait_drain();
				end
				5: begin
					if (c[0])
						exp_pc.push_back(b);
					raise_irq(a[irq_num_w-1:0]);
					// A dropped interrupt must stay silent
					if (c[0])
						wait_drain();
					else
						repeat (10) @(negedge clock);
				end
				6: begin
					exp_pc.push_back(c);
					exp_pc.push_back(d);
					swi_req = 1'b1;
					swi_num = a[irq_num_w-1:0];
					irq_valid = 1'b1;
					irq_num = b[irq_num_w-1:0];
					#1;
					while (!swi_ack && !irq_ack) begin
						@(negedge clock);
						#1;
					end
					if (irq_ack)
						abort_run("External interrupt was taken ahead of the software one");
					@(negedge clock);
					swi_req = 1'b0;
					raise_irq(b[irq_num_w-1:0]);
					wait_drain();
				end
				7: begin
					exp_pc.push_back(b);
					raise_swi(a[irq_num_w-1:0]);
				end
				9: wait_drain();
				default: abort_run($sformatf("Unknown trace op %0h at item %0d", op, idx));
			endcase
		end
		wait_drain();
		repeat (4) @(negedge clock);
		if (u_core_mem_top.u_ldst_pipe_arbiter.u_core_mem_assert.assert_fails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
source/core_mem_pkg.sv
source/ldst_req_if.sv
source/exe_ldst_queue.sv
source/irq_vector_unit.sv
source/ldst_pipe_arbiter.sv
source/core_mem_top.sv
tb/core_mem_assert.sv
tb/core_mem_tb.sv

//--- tb/core_mem_trace.txt
// One record per line: op a b c d, all hex
// 1 preload a=addr b=data | 2 ict write a=entry b=mask c=valid
// 3 store a=addr b=data c=order | 4 load and wait a=addr b=expected c=order
// 5 irq a=num b=expected pc c=taken | 6 swi with irq a=swi b=irq c=swi pc d=irq pc
// 7 swi a=num b=expected pc | 8 load without wait | 9 drain | 0 end
1 00000104 11223344 0 0
1 00002114 00008100 0 0
1 00002150 00008200 0 0
1 0000200C 00004300 0 0
1 0000201C 00004700 0 0
1 00002028 00004A00 0 0
1 00000200 01010101 0 0
1 00000204 02020202 0 0
1 00000208 03030303 0 0
1 0000020C 04040404 0 0
2 05 0 1 0
2 09 1 1 0
2 14 0 1 0
3 00000100 DEADBEEF 2 0
4 00000100 DEADBEEF 2 0
4 00000101 000000BE 0 0
4 00000103 000000DE 0 0
4 00000102 0000DEAD 1 0
4 00000100 0000BEEF 1 0
3 00000105 000000A7 0 0
4 00000104 1122A744 2 0
3 00000106 00009988 1 0
4 00000106 00009988 1 0
4 00000104 00000044 0 0
5 05 00008100 1 0
5 09 0 0 0
5 0C 0 0 0
5 14 00008200 1 0
6 03 05 00004300 00008100
8 00000200 01010101 2 0
8 00000204 02020202 2 0
7 07 00004700 0 0
8 00000208 03030303 2 0
8 0000020C 04040404 2 0
7 0A 00004A00 0 0
8 0000020D 00000004 0 0
9 0 0 0 0
0 0 0 0 0
